/* Bender.yml */
package:
  name: lsu

sources:
  - design/lsuPkg.sv
  - design/lsuAddrUnit.sv
  - design/storeLaneGen.sv
  - design/loadExtract.sv
  - design/lsuControl.sv
  - design/lsuTop.sv
  - target: simulation
    files:
      - testbench/lsuProperties_properties.sv
      - testbench/lsuTb.sv

/* design/loadExtract.sv */
module loadExtract (
    input  lsuPkg::lsuOp                  op,
    input  logic [1:0]                    laneSel,
    input  logic [lsuPkg::dataWidth-1:0]  respData,
    output logic [2:0]                    size,
    output logic [lsuPkg::dataWidth-1:0]  value
);

    logic [lsuPkg::dataWidth-1:0] shifted;
    logic [7:0]                   byteVal;
    logic [15:0]                  halfVal;

    // addressed byte lands in the low lane
    assign shifted = respData >> {laneSel, 3'b000};
    assign byteVal = shifted[7:0];
    assign halfVal = laneSel[1] ? respData[31:16] : respData[15:0];

    always_comb begin
        case (op)
            lsuPkg::lb: begin
                size  = lsuPkg::sizeByte;
                value = {{24{byteVal[7]}}, byteVal};
            end
            lsuPkg::lbu: begin
                size  = lsuPkg::sizeByte;
                value = {24'b0, byteVal};
            end
            lsuPkg::lh: begin
                size  = lsuPkg::sizeHalf;
                value = {{16{halfVal[15]}}, halfVal};
            end
            lsuPkg::lhu: begin
                size  = lsuPkg::sizeHalf;
                value = {16'b0, halfVal};
            end
            default: begin
                size  = lsuPkg::sizeWord;
                value = respData;
            end
        endcase
    end

endmodule

/* design/lsuAddrUnit.sv */
module lsuAddrUnit (
    input  lsuPkg::uopBundle              heldUop,
    input  lsuPkg::operandPair            heldOps,
    output logic [lsuPkg::dataWidth-1:0]  vAddr,
    output logic [lsuPkg::dataWidth-1:0]  pAddr,
    output logic                          misaligned
);

    logic inKseg0;
    logic inKseg1;

    assign vAddr = heldOps.rs0Data + heldUop.imm;

    // word needs both low bits clear, halfword only bit 0
    always_comb begin
        case (heldUop.op)
            lsuPkg::lw,
            lsuPkg::sw:  misaligned = |vAddr[1:0];
            lsuPkg::lh,
            lsuPkg::lhu,
            lsuPkg::sh:  misaligned = vAddr[0];
            default:     misaligned = 1'b0;
        endcase
    end

    assign inKseg0 = (vAddr >= lsuPkg::kseg0Base) && (vAddr <= lsuPkg::kseg0Limit);
    assign inKseg1 = (vAddr >= lsuPkg::kseg1Base) && (vAddr <= lsuPkg::kseg1Limit);

    // unmapped windows, everything else passes through
    always_comb begin
        if (inKseg0) begin
            pAddr = vAddr - lsuPkg::kseg0Base;
        end else if (inKseg1) begin
            pAddr = vAddr - lsuPkg::kseg1Base;
        end else begin
            pAddr = vAddr;
        end
    end

endmodule

/* design/lsuControl.sv */
module lsuControl (
    input  logic                          clk,
    input  logic                          rst,
    input  lsuPkg::uopBundle              uop,
    input  lsuPkg::operandPair            operands,
    output logic                          busy,
    input  logic                          fireStore,
    input  logic                          memReqReady,
    input  lsuPkg::memResp                resp,
    output logic                          memRespReady,
    output lsuPkg::writeBack              wb,
    output lsuPkg::commitInfo             commit,
    output lsuPkg::uopBundle              heldUop,
    output lsuPkg::operandPair            heldOps,
    input  logic [lsuPkg::dataWidth-1:0]  vAddr,
    input  logic [lsuPkg::dataWidth-1:0]  pAddr,
    input  logic                          misaligned,
    input  logic [2:0]                    storeSize,
    input  logic [2:0]                    loadSize,
    input  logic [3:0]                    storeStrobe,
    input  logic [lsuPkg::dataWidth-1:0]  storeData,
    input  logic [lsuPkg::dataWidth-1:0]  loadValue,
    output lsuPkg::memReq                 req
);

    typedef enum logic [2:0] {
        idle,
        addrError,
        loadReq,
        loadResp,
        storeHold,
        storeFire
    } lsuState;

    lsuState state;
    lsuState curState;
    lsuState nextState;
    logic    dispatch;
    logic    accept;
    logic    isLoad;
    logic    isStore;
    logic    loadDone;

    assign busy   = (state != idle) || dispatch;
    assign accept = uop.valid && !busy;

    assign isLoad  = heldUop.op inside {lsuPkg::lb, lsuPkg::lbu, lsuPkg::lh,
                                        lsuPkg::lhu, lsuPkg::lw};
    assign isStore = heldUop.op inside {lsuPkg::sb, lsuPkg::sh, lsuPkg::sw};

    ////////////////////
    // state
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= idle;
            dispatch <= 1'b0;
        end else begin
            state    <= nextState;
            dispatch <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            heldUop <= uop;
            heldOps <= operands;
        end
    end

    // first cycle after acceptance resolves the op class here
    always_comb begin
        curState = state;
        if (dispatch) begin
            if (misaligned) begin
                curState = addrError;
            end else if (isLoad) begin
                curState = loadReq;
            end else if (isStore) begin
                curState = storeHold;
            end else begin
                curState = idle;
            end
        end
    end

    always_comb begin
        nextState = curState;
        case (curState)
            idle:      nextState = idle;
            addrError: nextState = idle;
            loadReq:   nextState = memReqReady ? loadResp : loadReq;
            loadResp:  nextState = resp.valid ? idle : loadResp;
            // store waits here for the rob
            storeHold: nextState = fireStore ? storeFire : storeHold;
            storeFire: nextState = memReqReady ? idle : storeFire;
            default:   nextState = idle;
        endcase
    end

    ////////////////////
    // memory side
    ////////////////////

    always_comb begin
        req = '0;
        case (curState)
            loadReq: begin
                req.valid   = 1'b1;
                req.addr    = pAddr;
                req.size    = loadSize;
                req.writeEn = 1'b0;
            end
            storeFire: begin
                req.valid   = 1'b1;
                req.addr    = pAddr;
                req.size    = storeSize;
                req.writeEn = 1'b1;
                req.strobe  = storeStrobe;
                req.data    = storeData;
            end
            default: begin
                req = '0;
            end
        endcase
    end

    assign memRespReady = (curState == loadResp);
    assign loadDone     = (curState == loadResp) && resp.valid;

    ////////////////////
    // rob and regfile
    ////////////////////

    always_comb begin
        wb.wen   = loadDone;
        wb.rd    = heldUop.dstReg;
        wb.wdata = loadValue;
    end

    // stores finish early, the write itself comes after fireStore
    always_comb begin
        commit.finish    = (curState == addrError)
                         || ((curState == storeHold) && dispatch)
                         || loadDone;
        commit.id        = heldUop.id;
        commit.exception = (curState == addrError);
        commit.code      = isLoad ? lsuPkg::addrErrLoad : lsuPkg::addrErrStore;
        commit.badVAddr  = vAddr;
    end

endmodule

/* design/lsuPkg.sv */
package lsuPkg;

    ////////////////////
    // widths
    ////////////////////

    localparam int dataWidth    = 32;
    localparam int idWidth      = 6;
    localparam int regAddrWidth = 6;

    ////////////////////
    // address windows
    ////////////////////

    localparam logic [dataWidth-1:0] kseg0Base  = 32'h8000_0000;
    localparam logic [dataWidth-1:0] kseg0Limit = 32'h9FFF_FFFF;
    localparam logic [dataWidth-1:0] kseg1Base  = 32'hA000_0000;
    localparam logic [dataWidth-1:0] kseg1Limit = 32'hBFFF_FFFF;

    // memory size codes
    localparam logic [2:0] sizeByte = 3'd0;
    localparam logic [2:0] sizeHalf = 3'd1;
    localparam logic [2:0] sizeWord = 3'd2;

    typedef enum logic [3:0] {
        lb,
        lbu,
        lh,
        lhu,
        lw,
        sb,
        sh,
        sw,
        none
    } lsuOp;

    typedef enum logic [4:0] {
        addrErrLoad  = 5'd4,
        addrErrStore = 5'd5
    } excCode;

    ////////////////////
    // bundles
    ////////////////////

    typedef struct packed {
        logic                    valid;
        lsuOp                    op;
        logic [idWidth-1:0]      id;
        logic [regAddrWidth-1:0] dstReg;
        logic [dataWidth-1:0]    imm;
    } uopBundle;

    typedef struct packed {
        logic [dataWidth-1:0] rs0Data;
        logic [dataWidth-1:0] rs1Data;
    } operandPair;

    typedef struct packed {
        logic                 valid;
        logic [dataWidth-1:0] addr;
        logic [2:0]           size;
        logic                 writeEn;
        logic [3:0]           strobe;
        logic [dataWidth-1:0] data;
    } memReq;

    typedef struct packed {
        logic                 valid;
        logic [dataWidth-1:0] data;
    } memResp;

    typedef struct packed {
        logic                    wen;
        logic [regAddrWidth-1:0] rd;
        logic [dataWidth-1:0]    wdata;
    } writeBack;

    // toward the reorder buffer
    typedef struct packed {
        logic                 finish;
        logic [idWidth-1:0]   id;
        logic                 exception;
        excCode               code;
        logic [dataWidth-1:0] badVAddr;
    } commitInfo;

endpackage

/* design/lsuTop.sv */
module lsuTop (
    input  logic               clk,
    input  logic               rst,
    input  lsuPkg::uopBundle   uop,
    input  lsuPkg::operandPair operands,
    output logic               busy,
    input  logic               fireStore,
    output lsuPkg::memReq      req,
    input  logic               memReqReady,
    input  lsuPkg::memResp     resp,
    output logic               memRespReady,
    output lsuPkg::writeBack   wb,
    output lsuPkg::commitInfo  commit
);

    lsuPkg::uopBundle                heldUop;
    lsuPkg::operandPair              heldOps;
    logic [lsuPkg::dataWidth-1:0]    vAddr;
    logic [lsuPkg::dataWidth-1:0]    pAddr;
    logic                            misaligned;
    logic [2:0]                      storeSize;
    logic [2:0]                      loadSize;
    logic [3:0]                      storeStrobe;
    logic [lsuPkg::dataWidth-1:0]    storeData;
    logic [lsuPkg::dataWidth-1:0]    loadValue;

    lsuControl control (
        .clk          (clk),
        .rst          (rst),
        .uop          (uop),
        .operands     (operands),
        .busy         (busy),
        .fireStore    (fireStore),
        .memReqReady  (memReqReady),
        .resp         (resp),
        .memRespReady (memRespReady),
        .wb           (wb),
        .commit       (commit),
        .heldUop      (heldUop),
        .heldOps      (heldOps),
        .vAddr        (vAddr),
        .pAddr        (pAddr),
        .misaligned   (misaligned),
        .storeSize    (storeSize),
        .loadSize     (loadSize),
        .storeStrobe  (storeStrobe),
        .storeData    (storeData),
        .loadValue    (loadValue),
        .req          (req)
    );

    lsuAddrUnit addrUnit (
        .heldUop    (heldUop),
        .heldOps    (heldOps),
        .vAddr      (vAddr),
        .pAddr      (pAddr),
        .misaligned (misaligned)
    );

    // lanes follow the physical address for stores
    storeLaneGen storeLanes (
        .op      (heldUop.op),
        .rs1Data (heldOps.rs1Data),
        .laneSel (pAddr[1:0]),
        .size    (storeSize),
        .strobe  (storeStrobe),
        .data    (storeData)
    );

    loadExtract loadLanes (
        .op       (heldUop.op),
        .laneSel  (vAddr[1:0]),
        .respData (resp.data),
        .size     (loadSize),
        .value    (loadValue)
    );

endmodule

/* design/storeLaneGen.sv */
module storeLaneGen (
    input  lsuPkg::lsuOp                  op,
    input  logic [lsuPkg::dataWidth-1:0]  rs1Data,
    input  logic [1:0]                    laneSel,
    output logic [2:0]                    size,
    output logic [3:0]                    strobe,
    output logic [lsuPkg::dataWidth-1:0]  data
);

    logic [4:0] byteShift;
    logic [4:0] halfShift;

    // shift amounts in bits
    assign byteShift = {laneSel, 3'b000};
    assign halfShift = {laneSel[1], 4'b0000};

    always_comb begin
        case (op)
            lsuPkg::sb: begin
                size   = lsuPkg::sizeByte;
                strobe = 4'b0001 << laneSel;
                data   = rs1Data << byteShift;
            end
            lsuPkg::sh: begin
                size   = lsuPkg::sizeHalf;
                strobe = laneSel[1] ? 4'b1100 : 4'b0011;
                data   = rs1Data << halfShift;
            end
            lsuPkg::sw: begin
                size   = lsuPkg::sizeWord;
                strobe = 4'b1111;
                data   = rs1Data;
            end
            default: begin
                // not a store, no lanes enabled
                size   = lsuPkg::sizeWord;
                strobe = 4'b0000;
                data   = rs1Data;
            end
        endcase
    end

endmodule

/* testbench/lsuProperties_properties.sv */
module lsuProperties (
    input logic              clk,
    input logic              rst,
    input logic              busy,
    input lsuPkg::memReq     req,
    input logic              memReqReady,
    input lsuPkg::commitInfo commit
);

    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;

    // request holds still under back-pressure
    property reqStable;
        @(posedge clk) disable iff (rst)
        req.valid && !memReqReady |=> $stable(req);
    endproperty

    property busyWithReq;
        @(posedge clk) disable iff (rst)
        req.valid |-> busy;
    endproperty

    // a load keeps the unit busy while it waits for data
    property busyAfterLoadReq;
        @(posedge clk) disable iff (rst)
        req.valid && memReqReady && !req.writeEn |=> busy;
    endproperty

    property singleCommitPulse;
        @(posedge clk) disable iff (rst)
        commit.finish |=> !commit.finish;
    endproperty

    reqStableChk: assert property (reqStable)
        else begin
            $error("memory request changed while waiting for ready");
            failCount++;
        end
    busyWithReqChk: assert property (busyWithReq)
        else begin
            $error("memory request while busy is low");
            failCount++;
        end
    busyAfterLoadChk: assert property (busyAfterLoadReq)
        else begin
            $error("busy low right after a load request completed");
            failCount++;
        end
    commitPulseChk: assert property (singleCommitPulse)
        else begin
            $error("commit finish held for two cycles");
            failCount++;
        end

endmodule

/* testbench/lsuTb.sv */
module lsuTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int numOps     = 300;
    localparam int clkPeriod  = 40;
    localparam int watchdogNs = numOps * 40 * clkPeriod;

    logic               clk;
    logic               rst;
    lsuPkg::uopBundle   uop;
    lsuPkg::operandPair operands;
    logic               busy;
    logic               fireStore;
    lsuPkg::memReq      req;
    logic               memReqReady;
    lsuPkg::memResp     resp;
    logic               memRespReady;
    lsuPkg::writeBack   wb;
    lsuPkg::commitInfo  commit;

    integer      seed = 32'h020f_07e5;
    int          errors;
    int          checks;
    int          commits;
    logic [7:0]  mem [bit [31:0]];

    // the one micro-op in flight
    lsuPkg::lsuOp curOp;
    logic [5:0]   curId;
    logic [5:0]   curDst;
    logic [31:0]  curVAddr;
    logic [31:0]  curRs1;
    logic         curMis;
    logic         curDone;
    logic         storeArmed;
    logic         prevRst;

    lsuTop DUT (
        .clk          (clk),
        .rst          (rst),
        .uop          (uop),
        .operands     (operands),
        .busy         (busy),
        .fireStore    (fireStore),
        .req          (req),
        .memReqReady  (memReqReady),
        .resp         (resp),
        .memRespReady (memRespReady),
        .wb           (wb),
        .commit       (commit)
    );

    bind lsuTop lsuProperties props (
        .clk         (clk),
        .rst         (rst),
        .busy        (busy),
        .req         (req),
        .memReqReady (memReqReady),
        .commit      (commit)
    );

    always #(clkPeriod / 2) clk = ~clk;

    ////////////////////
    // reference model
    ////////////////////

    // unwritten bytes carry a pattern of their address
    function automatic logic [7:0] memByte(logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return addr[7:0] ^ 8'h5A;
    endfunction

    function automatic logic [31:0] physAddr(logic [31:0] vAddr);
        if (vAddr >= lsuPkg::kseg0Base && vAddr <= lsuPkg::kseg0Limit) begin
            return vAddr - lsuPkg::kseg0Base;
        end
        if (vAddr >= lsuPkg::kseg1Base && vAddr <= lsuPkg::kseg1Limit) begin
            return vAddr - lsuPkg::kseg1Base;
        end
        return vAddr;
    endfunction

    function automatic logic isLoadOp(lsuPkg::lsuOp op);
        return op inside {lsuPkg::lb, lsuPkg::lbu, lsuPkg::lh, lsuPkg::lhu, lsuPkg::lw};
    endfunction

    function automatic int accessBytes(lsuPkg::lsuOp op);
        case (op)
            lsuPkg::lb, lsuPkg::lbu, lsuPkg::sb: return 1;
            lsuPkg::lh, lsuPkg::lhu, lsuPkg::sh: return 2;
            default:                             return 4;
        endcase
    endfunction

    // memory size code from the access width
    function automatic logic [2:0] sizeCode(lsuPkg::lsuOp op);
        case (accessBytes(op))
            1:       return lsuPkg::sizeByte;
            2:       return lsuPkg::sizeHalf;
            default: return lsuPkg::sizeWord;
        endcase
    endfunction

    // little endian, lowest address is the least significant byte
    function automatic logic [31:0] expectedLoad(lsuPkg::lsuOp op, logic [31:0] pAddr);
        logic [31:0] raw;
        raw = '0;
        for (int i = 0; i < accessBytes(op); i++) begin
            raw[8*i +: 8] = memByte(pAddr + i);
        end
        case (op)
            lsuPkg::lb: return {{24{raw[7]}}, raw[7:0]};
            lsuPkg::lh: return {{16{raw[15]}}, raw[15:0]};
            default:    return raw;
        endcase
    endfunction

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkTrue(logic cond, string what);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    ////////////////////
    // memory responder
    ////////////////////

    initial begin
        int          readyWait;
        int          respWait;
        logic        respPending;
        logic [31:0] respAddr;
        memReqReady = 1'b0;
        resp        = '0;
        respPending = 1'b0;
        respAddr    = '0;
        respWait    = 0;
        readyWait   = $unsigned($random(seed)) % 4;
        forever begin
            @(posedge clk);
            if (rst) begin
                memReqReady <= 1'b0;
                resp        <= '0;
                respPending = 1'b0;
            end else begin
                if (resp.valid && memRespReady) begin
                    resp <= '0;
                end
                if (req.valid && memReqReady) begin
                    memReqReady <= 1'b0;
                    readyWait   = $unsigned($random(seed)) % 4;
                    if (!req.writeEn) begin
                        respPending = 1'b1;
                        respAddr    = {req.addr[31:2], 2'b00};
                        respWait    = $unsigned($random(seed)) % 4;
                    end
                end else if (req.valid) begin
                    if (readyWait == 0) begin
                        memReqReady <= 1'b1;
                    end else begin
                        readyWait--;
                    end
                end
                if (respPending) begin
                    if (respWait == 0) begin
                        resp <= '{valid: 1'b1, data: {memByte(respAddr + 3), memByte(respAddr + 2),
                                                      memByte(respAddr + 1), memByte(respAddr)}};
                        respPending = 1'b0;
                    end else begin
                        respWait--;
                    end
                end
            end
        end
    end

    ////////////////////
    // checks
    ////////////////////

    always @(negedge clk) begin
        logic [31:0] pAddr;
        logic [3:0]  strobe;
        logic [31:0] wdata;
        pAddr = physAddr(curVAddr);
        if (rst || prevRst) begin
            checkTrue(!busy && !req.valid && !memRespReady && !commit.finish && !wb.wen,
                      "outputs not idle during or right after reset");
        end else begin
            if (fireStore) begin
                storeArmed = 1'b0;
            end
            if (req.valid && req.writeEn) begin
                checkTrue(!storeArmed, "write request before fireStore");
            end
            if (req.valid) begin
                checkTrue(!curMis, "memory request issued for a misaligned access");
            end
            // handshake completes on the coming edge
            if (req.valid && memReqReady) begin
                checkValue("reqAddr", pAddr, req.addr);
                checkValue("reqWriteEn", !isLoadOp(curOp), req.writeEn);
                checkValue("reqSize", sizeCode(curOp), req.size);
                if (req.writeEn) begin
                    strobe = 4'((1 << accessBytes(curOp)) - 1) << pAddr[1:0];
                    wdata  = curRs1 << (8 * pAddr[1:0]);
                    checkValue("storeStrobe", strobe, req.strobe);
                    checkValue("storeData", wdata, req.data);
                    for (int i = 0; i < 4; i++) begin
                        if (strobe[i]) begin
                            mem[{pAddr[31:2], 2'(i)}] = wdata[8*i +: 8];
                        end
                    end
                end
            end
            if (wb.wen) begin
                checkTrue(commit.finish, "writeback without a commit pulse");
            end
            if (commit.finish) begin
                commits++;
                checkTrue(!curDone, "second commit for one micro-op");
                curDone = 1'b1;
                checkValue("commitId", curId, commit.id);
                checkValue("exception", curMis, commit.exception);
                if (curMis) begin
                    checkTrue(!wb.wen, "writeback for an access with an exception");
                    checkValue("excCode", isLoadOp(curOp) ? lsuPkg::addrErrLoad
                                                          : lsuPkg::addrErrStore, commit.code);
                    checkValue("badVAddr", curVAddr, commit.badVAddr);
                end else if (isLoadOp(curOp)) begin
                    checkTrue(wb.wen, "load commit without writeback");
                    checkValue("wbRd", curDst, wb.rd);
                    checkValue("loadData", expectedLoad(curOp, pAddr), wb.wdata);
                end else begin
                    checkTrue(!wb.wen, "writeback for a store");
                    storeArmed = 1'b1;
                end
            end
        end
        prevRst = rst;
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        lsuPkg::lsuOp op;
        int           bytes;
        int unsigned  region;
        logic [31:0]  offset;
        logic [31:0]  rs0;
        clk        = 1'b0;
        rst        = 1'b1;
        uop        = '0;
        operands   = '0;
        fireStore  = 1'b0;
        errors     = 0;
        checks     = 0;
        commits    = 0;
        curOp      = lsuPkg::none;
        curVAddr   = '0;
        curMis     = 1'b0;
        curDone    = 1'b1;
        storeArmed = 1'b0;
        prevRst    = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < numOps; n++) begin
            @(posedge clk);
            while (busy) @(posedge clk);
            op     = lsuPkg::lsuOp'($unsigned($random(seed)) % 8);
            bytes  = accessBytes(op);
            region = $unsigned($random(seed)) % 3;
            // small window so that the three regions alias onto the same bytes
            offset = $random(seed) & 32'h3F;
            offset = offset & ~32'(bytes - 1);
            if (bytes > 1 && $unsigned($random(seed)) % 100 < 24) begin
                offset = offset | (1 + $unsigned($random(seed)) % (bytes - 1));
            end
            case (region)
                0:       curVAddr = lsuPkg::kseg0Base + offset;
                1:       curVAddr = lsuPkg::kseg1Base + offset;
                default: curVAddr = offset;
            endcase
            rs0     = $random(seed);
            curOp   = op;
            curId   = 6'($random(seed));
            curDst  = 6'($random(seed));
            curRs1  = $random(seed);
            curMis  = (bytes == 4 && curVAddr[1:0] != 2'b00) || (bytes == 2 && curVAddr[0]);
            curDone = 1'b0;
            uop      <= '{valid: 1'b1, op: op, id: curId, dstReg: curDst, imm: curVAddr - rs0};
            operands <= '{rs0Data: rs0, rs1Data: curRs1};
            @(posedge clk);
            uop.valid <= 1'b0;
            if (!isLoadOp(op) && !curMis) begin
                @(posedge clk);
                while (!commit.finish) @(posedge clk);
                repeat (1 + $unsigned($random(seed)) % 5) @(posedge clk);
                fireStore <= 1'b1;
                @(posedge clk);
                fireStore <= 1'b0;
            end
        end
        @(posedge clk);
        while (busy) @(posedge clk);
        repeat (4) @(posedge clk);
        checkValue("commitCount", numOps, commits);
        errors = errors + DUT.props.failCount;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(watchdogNs);
        $display("timeout: run did not finish within %0d ns", watchdogNs);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("tests failed");
        $finish;
    end

endmodule

/* vlog.f */
design/lsuPkg.sv
design/lsuAddrUnit.sv
design/storeLaneGen.sv
design/loadExtract.sv
design/lsuControl.sv
design/lsuTop.sv
testbench/lsuProperties_properties.sv
testbench/lsuTb.sv
